/* verilog/nf_stream_pkg.sv */
// pipeline-side stream definitions
// metadata vector, size and port mask types
// metadata field positions and host destination bits

package nf_stream_pkg;

  // full width of the pipeline metadata word
  localparam int TUSER_WIDTH = 128;

  typedef logic [TUSER_WIDTH-1:0] nf_tuser_t;

  // packet length in bytes
  typedef logic [15:0] pkt_size_t;

  // one-hot interface mask, one bit per physical port
  typedef logic [7:0] port_mask_t;

  // metadata layout
  localparam int SIZE_LSB     = 0;
  localparam int SRC_PORT_LSB = 16;
  localparam int DST_PORT_LSB = 24;

  // host bits inside a port mask, mac ports sit on the even bits
  localparam int HOST0_DST_BIT = 1;
  localparam int HOST1_DST_BIT = 3;

endpackage

/* verilog/qdma_pkg.sv */
// host-side channel definitions
// length and port word types, interface numbers, destination codes

package qdma_pkg;

  // host length field
  typedef logic [15:0] qdma_size_t;

  // host source and destination word
  typedef logic [15:0] qdma_port_t;

  // index of one of the two host channels
  typedef logic chan_sel_t;

  // source masks written into the pipeline metadata
  localparam logic [7:0] HOST0_IFNUM = 8'b0000_0010;
  localparam logic [7:0] HOST1_IFNUM = 8'b0000_1000;

  // destination words presented to the host on c2h
  localparam qdma_port_t HOST0_DST_CODE = 16'h0001;
  localparam qdma_port_t HOST1_DST_CODE = 16'h0002;

endpackage

/* verilog/nf_stream_if.sv */
// pipeline stream bundle
// producer and consumer modports

`timescale 1ns/1ns

interface nf_stream_if
  import nf_stream_pkg::*;
#(
  parameter int TDATA_WIDTH = 512
) ();

  logic [TDATA_WIDTH-1:0]   tdata;
  logic [TDATA_WIDTH/8-1:0] tkeep;
  nf_tuser_t                tuser;
  logic                     tvalid;
  logic                     tlast;
  logic                     tready;

  modport producer (
    output tdata, tkeep, tuser, tvalid, tlast,
    input  tready
  );

  modport consumer (
    input  tdata, tkeep, tuser, tvalid, tlast,
    output tready
  );

endinterface

/* verilog/h2c_arbiter.sv */
// host-to-card merge of the two host channels
// packet round-robin grant, beat mux, pipeline metadata tagging

`timescale 1ns/1ns

module h2c_arbiter
  import nf_stream_pkg::*, qdma_pkg::*;
#(
  parameter int TDATA_WIDTH = 512
) (
  input  logic                     axis_aclk,
  input  logic                     axis_rst,

  input  logic                     h2c_0_tvalid,
  input  logic [TDATA_WIDTH-1:0]   h2c_0_tdata,
  input  logic [TDATA_WIDTH/8-1:0] h2c_0_tkeep,
  input  logic                     h2c_0_tlast,
  input  qdma_size_t               h2c_0_tuser_size,
  input  qdma_port_t               h2c_0_tuser_src,
  input  qdma_port_t               h2c_0_tuser_dst,
  output logic                     h2c_0_tready,

  input  logic                     h2c_1_tvalid,
  input  logic [TDATA_WIDTH-1:0]   h2c_1_tdata,
  input  logic [TDATA_WIDTH/8-1:0] h2c_1_tkeep,
  input  logic                     h2c_1_tlast,
  input  qdma_size_t               h2c_1_tuser_size,
  input  qdma_port_t               h2c_1_tuser_src,
  input  qdma_port_t               h2c_1_tuser_dst,
  output logic                     h2c_1_tready,

  nf_stream_if.producer            pipe
);

  typedef enum logic {
    IDLE,
    BUSY
  } arb_state_t;

  arb_state_t state;
  chan_sel_t  grant;
  chan_sel_t  pref;
  chan_sel_t  pick;
  chan_sel_t  sel;

  logic [1:0]               in_valid;
  logic [1:0]               in_last;
  logic [TDATA_WIDTH-1:0]   in_data [2];
  logic [TDATA_WIDTH/8-1:0] in_keep [2];
  qdma_size_t               in_size [2];

  logic xfer;
  logic pkt_end;

  // host src and dst words are not carried, the source comes from the channel
  assign in_valid   = {h2c_1_tvalid, h2c_0_tvalid};
  assign in_last    = {h2c_1_tlast, h2c_0_tlast};
  assign in_data[0] = h2c_0_tdata;
  assign in_data[1] = h2c_1_tdata;
  assign in_keep[0] = h2c_0_tkeep;
  assign in_keep[1] = h2c_1_tkeep;
  assign in_size[0] = h2c_0_tuser_size;
  assign in_size[1] = h2c_1_tuser_size;

  // preferred channel first, otherwise whichever one is waiting
  assign pick = in_valid[pref] ? pref : ~pref;

  // in IDLE the choice is live so a first beat goes through with no delay
  assign sel = (state == IDLE) ? pick : grant;

  assign xfer    = in_valid[sel] && pipe.tready;
  assign pkt_end = xfer && in_last[sel];

  assign pipe.tvalid = in_valid[sel];
  assign pipe.tdata  = in_data[sel];
  assign pipe.tkeep  = in_keep[sel];
  assign pipe.tlast  = in_last[sel];

  always_comb begin
    pipe.tuser = '0;
    pipe.tuser[SIZE_LSB +: $bits(pkt_size_t)] = pkt_size_t'(in_size[sel]);
    pipe.tuser[SRC_PORT_LSB +: $bits(port_mask_t)] = sel ? HOST1_IFNUM : HOST0_IFNUM;
  end

  // only the selected channel sees the pipeline ready
  assign h2c_0_tready = (sel == 1'b0) && pipe.tready;
  assign h2c_1_tready = (sel == 1'b1) && pipe.tready;

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state <= IDLE;
      grant <= 1'b0;
      pref  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // lock the choice as soon as a beat is offered
          if (in_valid[sel]) begin
            grant <= sel;
            if (pkt_end) begin
              pref <= ~sel;
            end else begin
              state <= BUSY;
            end
          end
        end
        BUSY: begin
          if (pkt_end) begin
            state <= IDLE;
            pref  <= ~grant;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // a channel keeps the pipeline from its first offered beat until its last beat has gone
  a_grant_held: assert property (
    @(posedge axis_aclk) disable iff (axis_rst)
    ((state == BUSY) || pipe.tvalid) && !pkt_end |=> $stable(sel)
  );

  // a stalled beat on the pipeline stays put, including its metadata
  a_pipe_stable: assert property (
    @(posedge axis_aclk) disable iff (axis_rst)
    pipe.tvalid && !pipe.tready |=> pipe.tvalid && $stable(pipe.tuser)
  );

endmodule

/* verilog/c2h_router.sv */
// card-to-host routing of the pipeline stream
// destination decode, first/body FSM, held size and destination

`timescale 1ns/1ns

module c2h_router
  import nf_stream_pkg::*, qdma_pkg::*;
#(
  parameter int TDATA_WIDTH = 512
) (
  input  logic                     axis_aclk,
  input  logic                     axis_rst,

  nf_stream_if.consumer            pipe,

  output logic                     c2h_0_tvalid,
  output logic [TDATA_WIDTH-1:0]   c2h_0_tdata,
  output logic [TDATA_WIDTH/8-1:0] c2h_0_tkeep,
  output logic                     c2h_0_tlast,
  output qdma_size_t               c2h_0_tuser_size,
  output qdma_port_t               c2h_0_tuser_src,
  output qdma_port_t               c2h_0_tuser_dst,
  input  logic                     c2h_0_tready,

  output logic                     c2h_1_tvalid,
  output logic [TDATA_WIDTH-1:0]   c2h_1_tdata,
  output logic [TDATA_WIDTH/8-1:0] c2h_1_tkeep,
  output logic                     c2h_1_tlast,
  output qdma_size_t               c2h_1_tuser_size,
  output qdma_port_t               c2h_1_tuser_src,
  output qdma_port_t               c2h_1_tuser_dst,
  input  logic                     c2h_1_tready
);

  typedef enum logic {
    FIRST,
    BODY
  } route_state_t;

  route_state_t state;

  port_mask_t in_dst;
  port_mask_t in_src;
  pkt_size_t  in_size;

  // bit 0 targets host 0, bit 1 targets host 1
  logic [1:0] tgt_in;
  logic [1:0] tgt_q;
  logic [1:0] tgt;

  pkt_size_t  size_q;
  port_mask_t src_q;
  pkt_size_t  size;
  port_mask_t src;

  logic xfer;

  assign in_size = pipe.tuser[SIZE_LSB +: $bits(pkt_size_t)];
  assign in_src  = pipe.tuser[SRC_PORT_LSB +: $bits(port_mask_t)];
  assign in_dst  = pipe.tuser[DST_PORT_LSB +: $bits(port_mask_t)];
  assign tgt_in  = {in_dst[HOST1_DST_BIT], in_dst[HOST0_DST_BIT]};

  // first beat decodes live, later beats reuse what the first one carried
  assign tgt  = (state == FIRST) ? tgt_in : tgt_q;
  assign size = (state == FIRST) ? in_size : size_q;
  assign src  = (state == FIRST) ? in_src : src_q;

  // wait only on the hosts this packet goes to, no target means drop
  assign pipe.tready = (!tgt[0] || c2h_0_tready) && (!tgt[1] || c2h_1_tready);
  assign xfer        = pipe.tvalid && pipe.tready;

  assign c2h_0_tvalid     = pipe.tvalid && tgt[0];
  assign c2h_0_tdata      = pipe.tdata;
  assign c2h_0_tkeep      = pipe.tkeep;
  assign c2h_0_tlast      = pipe.tlast;
  assign c2h_0_tuser_size = qdma_size_t'(size);
  assign c2h_0_tuser_src  = qdma_port_t'(src);
  assign c2h_0_tuser_dst  = tgt[0] ? HOST0_DST_CODE : '0;

  assign c2h_1_tvalid     = pipe.tvalid && tgt[1];
  assign c2h_1_tdata      = pipe.tdata;
  assign c2h_1_tkeep      = pipe.tkeep;
  assign c2h_1_tlast      = pipe.tlast;
  assign c2h_1_tuser_size = qdma_size_t'(size);
  assign c2h_1_tuser_src  = qdma_port_t'(src);
  assign c2h_1_tuser_dst  = tgt[1] ? HOST1_DST_CODE : '0;

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state <= FIRST;
      tgt_q <= 2'b00;
    end else begin
      case (state)
        FIRST: begin
          if (xfer && !pipe.tlast) begin
            state <= BODY;
            tgt_q <= tgt_in;
          end
        end
        BODY: begin
          if (xfer && pipe.tlast) begin
            state <= FIRST;
            tgt_q <= 2'b00;
          end
        end
        default: begin
          state <= FIRST;
        end
      endcase
    end
  end

  // size and source follow the first beat
  always_ff @(posedge axis_aclk) begin
    if ((state == FIRST) && xfer) begin
      size_q <= in_size;
      src_q  <= in_src;
    end
  end

  // route, size and source seen on the first beat hold until the last beat has gone
  a_route_held: assert property (
    @(posedge axis_aclk) disable iff (axis_rst)
    ((state == BODY) || xfer) && !(xfer && pipe.tlast)
      |=> $stable(tgt) && $stable(size) && $stable(src)
  );

endmodule

/* verilog/dma_attachment.sv */
// host DMA attachment top level
// plain host and pipeline ports mapped onto the internal stream bundles
// h2c merge toward the pipeline, c2h routing back to the hosts

`timescale 1ns/1ns

module dma_attachment
  import nf_stream_pkg::*, qdma_pkg::*;
#(
  parameter int TDATA_WIDTH = 512
) (
  input  logic                     axis_aclk,
  input  logic                     axis_rst,

  // host-to-card channel 0
  input  logic                     h2c_0_tvalid,
  input  logic [TDATA_WIDTH-1:0]   h2c_0_tdata,
  input  logic [TDATA_WIDTH/8-1:0] h2c_0_tkeep,
  input  logic                     h2c_0_tlast,
  input  qdma_size_t               h2c_0_tuser_size,
  input  qdma_port_t               h2c_0_tuser_src,
  input  qdma_port_t               h2c_0_tuser_dst,
  output logic                     h2c_0_tready,

  // host-to-card channel 1
  input  logic                     h2c_1_tvalid,
  input  logic [TDATA_WIDTH-1:0]   h2c_1_tdata,
  input  logic [TDATA_WIDTH/8-1:0] h2c_1_tkeep,
  input  logic                     h2c_1_tlast,
  input  qdma_size_t               h2c_1_tuser_size,
  input  qdma_port_t               h2c_1_tuser_src,
  input  qdma_port_t               h2c_1_tuser_dst,
  output logic                     h2c_1_tready,

  // card-to-host channel 0
  output logic                     c2h_0_tvalid,
  output logic [TDATA_WIDTH-1:0]   c2h_0_tdata,
  output logic [TDATA_WIDTH/8-1:0] c2h_0_tkeep,
  output logic                     c2h_0_tlast,
  output qdma_size_t               c2h_0_tuser_size,
  output qdma_port_t               c2h_0_tuser_src,
  output qdma_port_t               c2h_0_tuser_dst,
  input  logic                     c2h_0_tready,

  // card-to-host channel 1
  output logic                     c2h_1_tvalid,
  output logic [TDATA_WIDTH-1:0]   c2h_1_tdata,
  output logic [TDATA_WIDTH/8-1:0] c2h_1_tkeep,
  output logic                     c2h_1_tlast,
  output qdma_size_t               c2h_1_tuser_size,
  output qdma_port_t               c2h_1_tuser_src,
  output qdma_port_t               c2h_1_tuser_dst,
  input  logic                     c2h_1_tready,

  // merged host traffic into the pipeline
  output logic [TDATA_WIDTH-1:0]   pipe_out_tdata,
  output logic [TDATA_WIDTH/8-1:0] pipe_out_tkeep,
  output nf_tuser_t                pipe_out_tuser,
  output logic                     pipe_out_tvalid,
  output logic                     pipe_out_tlast,
  input  logic                     pipe_out_tready,

  // pipeline traffic bound for the hosts
  input  logic [TDATA_WIDTH-1:0]   pipe_in_tdata,
  input  logic [TDATA_WIDTH/8-1:0] pipe_in_tkeep,
  input  nf_tuser_t                pipe_in_tuser,
  input  logic                     pipe_in_tvalid,
  input  logic                     pipe_in_tlast,
  output logic                     pipe_in_tready
);

  nf_stream_if #(.TDATA_WIDTH(TDATA_WIDTH)) pipe_out_if ();
  nf_stream_if #(.TDATA_WIDTH(TDATA_WIDTH)) pipe_in_if ();

  assign pipe_out_tdata     = pipe_out_if.tdata;
  assign pipe_out_tkeep     = pipe_out_if.tkeep;
  assign pipe_out_tuser     = pipe_out_if.tuser;
  assign pipe_out_tvalid    = pipe_out_if.tvalid;
  assign pipe_out_tlast     = pipe_out_if.tlast;
  assign pipe_out_if.tready = pipe_out_tready;

  assign pipe_in_if.tdata  = pipe_in_tdata;
  assign pipe_in_if.tkeep  = pipe_in_tkeep;
  assign pipe_in_if.tuser  = pipe_in_tuser;
  assign pipe_in_if.tvalid = pipe_in_tvalid;
  assign pipe_in_if.tlast  = pipe_in_tlast;
  assign pipe_in_tready    = pipe_in_if.tready;

  h2c_arbiter #(
    .TDATA_WIDTH (TDATA_WIDTH)
  ) i_h2c_arbiter (
    .axis_aclk        (axis_aclk),
    .axis_rst         (axis_rst),
    .h2c_0_tvalid     (h2c_0_tvalid),
    .h2c_0_tdata      (h2c_0_tdata),
    .h2c_0_tkeep      (h2c_0_tkeep),
    .h2c_0_tlast      (h2c_0_tlast),
    .h2c_0_tuser_size (h2c_0_tuser_size),
    .h2c_0_tuser_src  (h2c_0_tuser_src),
    .h2c_0_tuser_dst  (h2c_0_tuser_dst),
    .h2c_0_tready     (h2c_0_tready),
    .h2c_1_tvalid     (h2c_1_tvalid),
    .h2c_1_tdata      (h2c_1_tdata),
    .h2c_1_tkeep      (h2c_1_tkeep),
    .h2c_1_tlast      (h2c_1_tlast),
    .h2c_1_tuser_size (h2c_1_tuser_size),
    .h2c_1_tuser_src  (h2c_1_tuser_src),
    .h2c_1_tuser_dst  (h2c_1_tuser_dst),
    .h2c_1_tready     (h2c_1_tready),
    .pipe             (pipe_out_if.producer)
  );

  c2h_router #(
    .TDATA_WIDTH (TDATA_WIDTH)
  ) i_c2h_router (
    .axis_aclk        (axis_aclk),
    .axis_rst         (axis_rst),
    .pipe             (pipe_in_if.consumer),
    .c2h_0_tvalid     (c2h_0_tvalid),
    .c2h_0_tdata      (c2h_0_tdata),
    .c2h_0_tkeep      (c2h_0_tkeep),
    .c2h_0_tlast      (c2h_0_tlast),
    .c2h_0_tuser_size (c2h_0_tuser_size),
    .c2h_0_tuser_src  (c2h_0_tuser_src),
    .c2h_0_tuser_dst  (c2h_0_tuser_dst),
    .c2h_0_tready     (c2h_0_tready),
    .c2h_1_tvalid     (c2h_1_tvalid),
    .c2h_1_tdata      (c2h_1_tdata),
    .c2h_1_tkeep      (c2h_1_tkeep),
    .c2h_1_tlast      (c2h_1_tlast),
    .c2h_1_tuser_size (c2h_1_tuser_size),
    .c2h_1_tuser_src  (c2h_1_tuser_src),
    .c2h_1_tuser_dst  (c2h_1_tuser_dst),
    .c2h_1_tready     (c2h_1_tready)
  );

endmodule

/* tests/tb_dma_model.svh */
// testbench model for the host DMA attachment
// beat types, xorshift generator, reference functions, typed compare tasks

`ifndef TB_DMA_MODEL_SVH
`define TB_DMA_MODEL_SVH

typedef struct packed {
  logic [DW-1:0]   data;
  logic [DW/8-1:0] keep;
  logic            last;
  qdma_size_t      tsize;
  qdma_port_t      src;
  qdma_port_t      dst;
} host_beat_t;

typedef struct packed {
  logic [DW-1:0]   data;
  logic [DW/8-1:0] keep;
  logic            last;
  nf_tuser_t       tuser;
} pipe_beat_t;

logic [31:0] rng_state = 32'h134a7ccc;
int          err_value = 0;
int          err_proto = 0;
int          err_timeout = 0;
string       test_name = "reset";

function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic logic [DW-1:0] rand_data();
  logic [DW-1:0] d;
  for (int k = 0; k < DW / 32; k++) begin
    d[k*32 +: 32] = next_rand();
  end
  return d;
endfunction

function automatic nf_tuser_t rand_tuser();
  nf_tuser_t t;
  for (int k = 0; k < 4; k++) begin
    t[k*32 +: 32] = next_rand();
  end
  return t;
endfunction

// size in bits 15..0, source mask in 23..16, everything else zero
function automatic nf_tuser_t h2c_tuser_ref(input qdma_size_t size, input logic ch);
  nf_tuser_t t;
  t = '0;
  t[15:0] = size;
  t[23:16] = ch ? 8'b0000_1000 : 8'b0000_0010;
  return t;
endfunction

// destination byte is 31..24, host 0 on bit 1 and host 1 on bit 3
function automatic logic [1:0] c2h_targets_ref(input nf_tuser_t t);
  return {t[27], t[25]};
endfunction

function automatic host_beat_t c2h_beat_ref(input pipe_beat_t b, input nf_tuser_t first,
                                           input logic ch);
  host_beat_t h;
  h.data  = b.data;
  h.keep  = b.keep;
  h.last  = b.last;
  h.tsize = first[15:0];
  h.src   = {8'h00, first[23:16]};
  h.dst   = ch ? 16'h0002 : 16'h0001;
  return h;
endfunction

task automatic check_tuser(input string what, input nf_tuser_t exp, input nf_tuser_t act);
  if (act !== exp) begin
    err_value++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_size(input string what, input qdma_size_t exp, input qdma_size_t act);
  if (act !== exp) begin
    err_value++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_port(input string what, input qdma_port_t exp, input qdma_port_t act);
  if (act !== exp) begin
    err_value++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_data(input string what, input logic [DW-1:0] exp,
                          input logic [DW-1:0] act);
  if (act !== exp) begin
    err_value++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

// keep and last together
task automatic check_ctrl(input string what, input logic [DW/8:0] exp, input logic [DW/8:0] act);
  if (act !== exp) begin
    err_value++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic proto_error(input string msg);
  err_proto++;
  $display("ERROR in %s: %s", test_name, msg);
endtask

`endif

/* tests/tb_dma_attachment.sv */
// testbench for the host DMA attachment top level
// queue-fed drivers, random ready, pipe_out and c2h monitors, test sequence

`timescale 1ns/1ns

module tb_dma_attachment
  import nf_stream_pkg::*, qdma_pkg::*;
();

  localparam int DW = 64;
  localparam int TIMEOUT = 2000;

  `include "tb_dma_model.svh"

  logic axis_aclk = 1'b0;
  logic axis_rst = 1'b1;
  logic rand_ready = 1'b0;

  host_beat_t h2c0_drv = '0;
  host_beat_t h2c1_drv = '0;
  pipe_beat_t pin_drv = '0;
  logic h2c0_valid = 1'b0;
  logic h2c1_valid = 1'b0;
  logic pin_valid = 1'b0;
  logic pipe_out_tready = 1'b1;
  logic c2h_0_tready = 1'b1;
  logic c2h_1_tready = 1'b1;

  logic            h2c_0_tready, h2c_1_tready, pipe_in_tready;
  logic            c2h_0_tvalid, c2h_0_tlast, c2h_1_tvalid, c2h_1_tlast;
  logic [DW-1:0]   c2h_0_tdata, c2h_1_tdata, pipe_out_tdata;
  logic [DW/8-1:0] c2h_0_tkeep, c2h_1_tkeep, pipe_out_tkeep;
  qdma_size_t      c2h_0_tuser_size, c2h_1_tuser_size;
  qdma_port_t      c2h_0_tuser_src, c2h_0_tuser_dst, c2h_1_tuser_src, c2h_1_tuser_dst;
  nf_tuser_t       pipe_out_tuser;
  logic            pipe_out_tvalid, pipe_out_tlast;

  // beats still to send, and beats each output is still owed
  host_beat_t h2c0_q[$];
  host_beat_t h2c1_q[$];
  pipe_beat_t pin_q[$];
  pipe_beat_t exp_pipe0[$];
  pipe_beat_t exp_pipe1[$];
  host_beat_t exp_c2h0[$];
  host_beat_t exp_c2h1[$];

  // packet tracking on pipe_out
  logic in_pkt = 1'b0;
  logic cur_ch = 1'b0;
  logic want_next = 1'b0;

  dma_attachment #(.TDATA_WIDTH(DW)) i_dut (
    .h2c_0_tvalid     (h2c0_valid),
    .h2c_0_tdata      (h2c0_drv.data),
    .h2c_0_tkeep      (h2c0_drv.keep),
    .h2c_0_tlast      (h2c0_drv.last),
    .h2c_0_tuser_size (h2c0_drv.tsize),
    .h2c_0_tuser_src  (h2c0_drv.src),
    .h2c_0_tuser_dst  (h2c0_drv.dst),
    .h2c_1_tvalid     (h2c1_valid),
    .h2c_1_tdata      (h2c1_drv.data),
    .h2c_1_tkeep      (h2c1_drv.keep),
    .h2c_1_tlast      (h2c1_drv.last),
    .h2c_1_tuser_size (h2c1_drv.tsize),
    .h2c_1_tuser_src  (h2c1_drv.src),
    .h2c_1_tuser_dst  (h2c1_drv.dst),
    .pipe_in_tdata    (pin_drv.data),
    .pipe_in_tkeep    (pin_drv.keep),
    .pipe_in_tuser    (pin_drv.tuser),
    .pipe_in_tvalid   (pin_valid),
    .pipe_in_tlast    (pin_drv.last),
    .*
  );

  initial begin
    forever #10 axis_aclk = ~axis_aclk;
  end

  // each source shows the front of its queue and drops it once taken
  always @(posedge axis_aclk) begin
    if (h2c0_valid && h2c_0_tready) begin
      void'(h2c0_q.pop_front());
    end
    if (h2c1_valid && h2c_1_tready) begin
      void'(h2c1_q.pop_front());
    end
    if (pin_valid && pipe_in_tready) begin
      void'(pin_q.pop_front());
    end
    h2c0_valid <= (h2c0_q.size() != 0);
    h2c1_valid <= (h2c1_q.size() != 0);
    pin_valid  <= (pin_q.size() != 0);
    if (h2c0_q.size() != 0) begin
      h2c0_drv <= h2c0_q[0];
    end
    if (h2c1_q.size() != 0) begin
      h2c1_drv <= h2c1_q[0];
    end
    if (pin_q.size() != 0) begin
      pin_drv <= pin_q[0];
    end
  end

  always @(posedge axis_aclk) begin : ready_gen
    logic [31:0] r;
    if (rand_ready) begin
      r = next_rand();
      pipe_out_tready <= r[0] | r[1];
      c2h_0_tready    <= r[2] | r[3];
      c2h_1_tready    <= r[4];
    end else begin
      pipe_out_tready <= 1'b1;
      c2h_0_tready    <= 1'b1;
      c2h_1_tready    <= 1'b1;
    end
  end

  always @(posedge axis_aclk) begin : mon_pipe_out
    logic h0_x;
    logic h1_x;
    logic ch;
    pipe_beat_t want;
    h0_x = h2c0_valid && h2c_0_tready;
    h1_x = h2c1_valid && h2c_1_tready;
    if (!axis_rst) begin
      if (h0_x && h1_x) begin
        proto_error("both host channels transferred in the same cycle");
      end
      if ((h0_x || h1_x) != (pipe_out_tvalid && pipe_out_tready)) begin
        proto_error("host transfer and pipe_out transfer disagree");
      end
      if (pipe_out_tvalid && pipe_out_tready) begin
        ch = (pipe_out_tuser[23:16] == 8'b0000_1000);
        if (!ch && pipe_out_tuser[23:16] != 8'b0000_0010) begin
          proto_error("pipe_out beat carries an unknown source mask");
        end else if (in_pkt && ch != cur_ch) begin
          proto_error("packets from the two hosts interleaved on pipe_out");
        end else if (!in_pkt && want_next && ch == cur_ch) begin
          proto_error("same host granted twice while the other one waited");
        end else if (ch ? exp_pipe1.size() == 0 : exp_pipe0.size() == 0) begin
          proto_error("pipe_out beat with no packet pending on its host");
        end else begin
          if (ch) begin
            want = exp_pipe1.pop_front();
          end else begin
            want = exp_pipe0.pop_front();
          end
          check_data("pipe_out data", want.data, pipe_out_tdata);
          check_ctrl("pipe_out keep/last", {want.keep, want.last},
                     {pipe_out_tkeep, pipe_out_tlast});
          check_tuser("pipe_out tuser", want.tuser, pipe_out_tuser);
        end
        // the other host waiting at a packet end must win the next grant
        want_next = pipe_out_tlast && (ch ? h2c0_valid : h2c1_valid);
        in_pkt    = !pipe_out_tlast;
        cur_ch    = ch;
      end
    end
  end

  task automatic check_host_beat(input string chan, input host_beat_t exp, input host_beat_t act);
    check_data({chan, " data"}, exp.data, act.data);
    check_ctrl({chan, " keep/last"}, {exp.keep, exp.last}, {act.keep, act.last});
    check_size({chan, " size"}, exp.tsize, act.tsize);
    check_port({chan, " src"}, exp.src, act.src);
    check_port({chan, " dst"}, exp.dst, act.dst);
  endtask

  always @(posedge axis_aclk) begin : mon_c2h
    host_beat_t act;
    if (!axis_rst && pin_valid && pipe_in_tready) begin
      if (c2h_0_tvalid) begin
        act = {c2h_0_tdata, c2h_0_tkeep, c2h_0_tlast, c2h_0_tuser_size, c2h_0_tuser_src,
               c2h_0_tuser_dst};
        if (!c2h_0_tready) begin
          proto_error("pipe_in took a beat while host 0 was not ready");
        end
        if (exp_c2h0.size() == 0) begin
          proto_error("beat reached host 0 with no packet routed there");
        end else begin
          check_host_beat("c2h_0", exp_c2h0.pop_front(), act);
        end
      end
      if (c2h_1_tvalid) begin
        act = {c2h_1_tdata, c2h_1_tkeep, c2h_1_tlast, c2h_1_tuser_size, c2h_1_tuser_src,
               c2h_1_tuser_dst};
        if (!c2h_1_tready) begin
          proto_error("pipe_in took a beat while host 1 was not ready");
        end
        if (exp_c2h1.size() == 0) begin
          proto_error("beat reached host 1 with no packet routed there");
        end else begin
          check_host_beat("c2h_1", exp_c2h1.pop_front(), act);
        end
      end
    end
  end

  function automatic int beat_count();
    return 1 + int'(next_rand() % 32'd4);
  endfunction

  task automatic send_h2c(input logic ch, input int beats);
    host_beat_t b;
    pipe_beat_t e;
    qdma_size_t size;
    logic [DW/8-1:0] last_keep;
    last_keep = {(DW/8){1'b1}} >> (next_rand() % (DW/8));
    size = qdma_size_t'((beats - 1) * (DW/8) + $countones(last_keep));
    for (int i = 0; i < beats; i++) begin
      b.data  = rand_data();
      b.last  = (i == beats - 1);
      b.keep  = b.last ? last_keep : '1;
      b.tsize = size;
      b.src   = qdma_port_t'(next_rand());
      b.dst   = qdma_port_t'(next_rand());
      e = '{data: b.data, keep: b.keep, last: b.last, tuser: h2c_tuser_ref(size, ch)};
      if (ch) begin
        h2c1_q.push_back(b);
        exp_pipe1.push_back(e);
      end else begin
        h2c0_q.push_back(b);
        exp_pipe0.push_back(e);
      end
    end
  endtask

  // later beats carry fresh metadata that the router must ignore
  task automatic send_c2h(input port_mask_t dst, input int beats);
    pipe_beat_t b;
    nf_tuser_t first;
    logic [1:0] tgt;
    first = rand_tuser();
    first[31:24] = dst;
    tgt = c2h_targets_ref(first);
    for (int i = 0; i < beats; i++) begin
      b.data  = rand_data();
      b.last  = (i == beats - 1);
      b.keep  = b.last ? ({(DW/8){1'b1}} >> (next_rand() % (DW/8))) : '1;
      b.tuser = first;
      if (i != 0) begin
        b.tuser = rand_tuser();
      end
      pin_q.push_back(b);
      if (tgt[0]) begin
        exp_c2h0.push_back(c2h_beat_ref(b, first, 1'b0));
      end
      if (tgt[1]) begin
        exp_c2h1.push_back(c2h_beat_ref(b, first, 1'b1));
      end
    end
  endtask

  function automatic logic traffic_pending();
    return (h2c0_q.size() + h2c1_q.size() + pin_q.size() + exp_pipe0.size()
            + exp_pipe1.size() + exp_c2h0.size() + exp_c2h1.size()) != 0;
  endfunction

  task automatic finish_run();
    $display("errors: value %0d, protocol %0d, timeout %0d", err_value, err_proto, err_timeout);
    if (err_value + err_proto + err_timeout == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (traffic_pending() && cycles < TIMEOUT) begin
      @(negedge axis_aclk);
      cycles++;
    end
    if (traffic_pending()) begin
      err_timeout++;
      $display("timeout in %s: beats were lost or never delivered", test_name);
    end
  endtask

  initial begin
    repeat (8) @(posedge axis_aclk);
    axis_rst <= 1'b0;
    @(negedge axis_aclk);

    test_name = "h2c_tag";
    repeat (4) send_h2c(1'b0, beat_count());
    wait_drain();
    repeat (4) send_h2c(1'b1, beat_count());
    wait_drain();

    test_name = "h2c_arb";
    repeat (6) begin
      send_h2c(1'b0, beat_count());
      send_h2c(1'b1, beat_count());
    end
    wait_drain();

    test_name = "h2c_bp";
    rand_ready = 1'b1;
    repeat (8) begin
      send_h2c(1'b0, beat_count());
      send_h2c(1'b1, beat_count());
    end
    wait_drain();
    rand_ready = 1'b0;

    test_name = "c2h_route";
    send_c2h(8'b0000_0010, beat_count());
    send_c2h(8'b0000_1000, beat_count());
    send_c2h(8'b0000_1010, beat_count());
    wait_drain();

    // mac-only and empty masks are dropped
    test_name = "c2h_hold";
    send_c2h(8'b0000_0010, 4);
    send_c2h(8'b0000_0000, 3);
    send_c2h(8'b0000_0101, 2);
    send_c2h(8'b0000_1000, 4);
    wait_drain();

    test_name = "c2h_bp";
    rand_ready = 1'b1;
    repeat (12) send_c2h(port_mask_t'(next_rand()), beat_count());
    wait_drain();
    rand_ready = 1'b0;

    finish_run();
  end

endmodule

/* verilog.f */
+incdir+tests
verilog/nf_stream_pkg.sv
verilog/qdma_pkg.sv
verilog/nf_stream_if.sv
verilog/h2c_arbiter.sv
verilog/c2h_router.sv
verilog/dma_attachment.sv
tests/tb_dma_attachment.sv
